// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_nand_master
FILELIST  = nand_master.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	elif ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: nand_master.f
src/nand_pkg.sv
src/nand_ifs.sv
src/nand_cycle_unit.sv
src/nand_wait_timer.sv
src/nand_command_fsm.sv
src/nand_master.sv
testbench/nand_chip_model.sv
testbench/tb_nand_master.sv

// File: src/nand_command_fsm.sv
//--------------------------------------------------------------------------
// NAND command FSM
// Decodes host opcodes, sequences bus cycles and delays,
// and holds the status register and the CE# and WP# pins
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module nand_command_fsm #(
	parameter int T_WB  = 10,
	parameter int T_WHR = 6
) (
	input  logic                        clk,
	input  logic                        nreset,
	input  logic                        activate,
	input  nand_pkg::nand_op_t          cmd_in,
	input  logic [nand_pkg::DATA_W-1:0] data_in,
	output logic [nand_pkg::DATA_W-1:0] data_out,
	output logic                        busy,
	output logic                        nce,
	output logic                        nwp,
	nand_cycle_if.ctrl                  cyc,
	nand_timer_if.ctrl                  tmr
);
	import nand_pkg::*;

	fsm_state_t        state;
	nand_op_t          op_q;
	logic [DATA_W-1:0] data_q;
	logic [1:0]        step;
	logic [7:0]        status;

	logic op_valid;
	logic op_local;
	logic use_cycle;
	logic seq_last;
	logic step_done;

	// Opcode classes
	assign op_valid = (cmd_in >= OP_NAND_RESET) && (cmd_in <= OP_BYPASS_DATA_RD);
	// Controller-only, never touch the bus
	assign op_local = (cmd_in >= OP_GET_STATUS) && (cmd_in <= OP_WRITE_ENABLE);

	//----------------------------------------------------------------------
	// Sequence table, one entry per opcode and step
	//----------------------------------------------------------------------
	always_comb begin
		use_cycle      = 1'b1;
		seq_last       = 1'b0;
		cyc.kind       = CYC_CMD;
		cyc.wdata      = data_q;
		tmr.count      = DELAY_W'(T_WB);
		tmr.wait_ready = 1'b1;
		case (op_q)
			// FF, then tWB and R/B#
			OP_NAND_RESET: begin
				cyc.wdata = NAND_CMD_RESET;
				use_cycle = (step == 2'd0);
				seq_last  = (step != 2'd0);
			end
			// 70, tWHR, one read
			OP_READ_STATUS: begin
				cyc.wdata = NAND_CMD_READ_STATUS;
				if (step == 2'd1) begin
					use_cycle      = 1'b0;
					tmr.count      = DELAY_W'(T_WHR);
					tmr.wait_ready = 1'b0;
				end else if (step == 2'd2) begin
					cyc.kind = CYC_READ;
					seq_last = 1'b1;
				end
			end
			// Raw byte, then tWB and R/B#
			OP_BYPASS_COMMAND, OP_BYPASS_ADDRESS: begin
				if (op_q == OP_BYPASS_ADDRESS) begin
					cyc.kind = CYC_ADDR;
				end
				use_cycle = (step == 2'd0);
				seq_last  = (step != 2'd0);
			end
			OP_BYPASS_DATA_WR: begin
				cyc.kind = CYC_WRITE;
				seq_last = 1'b1;
			end
			// Bypass read, a single read cycle
			default: begin
				cyc.kind = CYC_READ;
				seq_last = 1'b1;
			end
		endcase
	end

	// Start pulses only from the issue state
	assign cyc.start = (state == ST_ISSUE) && use_cycle;
	assign tmr.start = (state == ST_ISSUE) && !use_cycle;

	assign step_done = (state == ST_WAIT_CYCLE && !cyc.busy) ||
		(state == ST_WAIT_TIMER && tmr.done);

	//----------------------------------------------------------------------
	// State, busy and chip pins
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			state  <= ST_IDLE;
			busy   <= 1'b0;
			step   <= 2'd0;
			status <= STATUS_RESET;
			nce    <= 1'b1;
			nwp    <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					// Invalid opcodes are dropped here
					if (activate && op_valid) begin
						busy  <= 1'b1;
						step  <= 2'd0;
						state <= op_local ? ST_FINISH : ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					state <= use_cycle ? ST_WAIT_CYCLE : ST_WAIT_TIMER;
				end
				ST_WAIT_CYCLE, ST_WAIT_TIMER: begin
					if (step_done) begin
						if (seq_last) begin
							state <= ST_FINISH;
						end else begin
							step  <= step + 2'd1;
							state <= ST_ISSUE;
						end
					end
				end
				ST_FINISH: begin
					busy  <= 1'b0;
					state <= ST_IDLE;
					case (op_q)
						OP_CHIP_ENABLE: begin
							nce                   <= 1'b0;
							status[STATUS_CE_BIT] <= 1'b1;
						end
						OP_CHIP_DISABLE: begin
							nce                   <= 1'b1;
							status[STATUS_CE_BIT] <= 1'b0;
						end
						OP_WRITE_PROTECT: begin
							nwp                   <= 1'b0;
							status[STATUS_WP_BIT] <= 1'b1;
						end
						OP_WRITE_ENABLE: begin
							nwp                   <= 1'b1;
							status[STATUS_WP_BIT] <= 1'b0;
						end
						default: begin
						end
					endcase
				end
				default: begin
					busy  <= 1'b0;
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Opcode, operand and host read-back
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && activate) begin
			op_q   <= cmd_in;
			data_q <= data_in;
		end
		if (state == ST_FINISH) begin
			if (op_q == OP_GET_STATUS) begin
				data_out <= status;
			end else if (op_q == OP_READ_STATUS || op_q == OP_BYPASS_DATA_RD) begin
				data_out <= cyc.rdata;
			end
		end
	end

	// Host busy tracks the FSM state
	a_busy_state: assert property (@(posedge clk) disable iff (!nreset)
		busy == (state != ST_IDLE));

endmodule

// File: src/nand_cycle_unit.sv
//--------------------------------------------------------------------------
// NAND bus-cycle unit
// Shapes one command, address, write or read cycle on the chip pins
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module nand_cycle_unit #(
	parameter int T_WP = 2
) (
	input  logic                        clk,
	input  logic                        nreset,
	nand_cycle_if.unit                  cyc,
	output logic                        cle,
	output logic                        ale,
	output logic                        nwe,
	output logic                        nre,
	output logic [nand_pkg::DATA_W-1:0] dq_out,
	output logic                        dq_oe,
	input  logic [nand_pkg::DATA_W-1:0] dq_in
);
	import nand_pkg::*;

	// Phase 0 is setup, 1 to T_WP strobe low and T_WP+1 hold
	localparam int              PH_W      = $clog2(T_WP + 2);
	localparam logic [PH_W-1:0] PH_SAMPLE = PH_W'(T_WP);
	localparam logic [PH_W-1:0] PH_LAST   = PH_W'(T_WP + 1);

	logic [PH_W-1:0] phase;
	cycle_kind_t     kind_q;
	logic            strobe;

	// Phase counter and busy flag
	always_ff @(posedge clk) begin
		if (!nreset) begin
			cyc.busy <= 1'b0;
			phase    <= '0;
		end else if (cyc.start) begin
			cyc.busy <= 1'b1;
			phase    <= '0;
		end else if (cyc.busy) begin
			// Release the bus after the hold phase
			if (phase == PH_LAST) begin
				cyc.busy <= 1'b0;
				phase    <= '0;
			end else begin
				phase <= phase + PH_W'(1);
			end
		end
	end

	// Cycle kind and write byte are taken on start
	always_ff @(posedge clk) begin
		if (cyc.start) begin
			kind_q <= cyc.kind;
			dq_out <= cyc.wdata;
		end
		// Sample read data on the last low cycle of RE#
		if (cyc.busy && kind_q == CYC_READ && phase == PH_SAMPLE) begin
			cyc.rdata <= dq_in;
		end
	end

	// WE# or RE# low window
	assign strobe = cyc.busy && (phase != '0) && (phase != PH_LAST);

	// Latch enables stay up through setup, strobe and hold
	assign cle = cyc.busy && (kind_q == CYC_CMD);
	assign ale = cyc.busy && (kind_q == CYC_ADDR);

	assign nwe = !(strobe && kind_q != CYC_READ);
	assign nre = !(strobe && kind_q == CYC_READ);

	// Drive the bus for everything except reads
	assign dq_oe = cyc.busy && (kind_q != CYC_READ);

	// Each WE# or RE# low pulse lasts exactly T_WP cycles
	a_strobe_width: assert property (@(posedge clk) disable iff (!nreset)
		$rose(nwe && nre) |->
			!$past(nwe && nre, T_WP) && $past(nwe && nre, T_WP + 1));

	// FSM must wait for the previous cycle to end
	a_start_when_idle: assert property (@(posedge clk) disable iff (!nreset)
		cyc.start |-> !cyc.busy);

endmodule

// File: src/nand_ifs.sv
//--------------------------------------------------------------------------
// Internal handshake interfaces of the NAND bus master
// One for the bus-cycle unit, one for the wait timer
//--------------------------------------------------------------------------

`timescale 1ns/1ps

// FSM to bus-cycle unit
// start is a one-cycle pulse, only while busy is low
interface nand_cycle_if;
	import nand_pkg::*;

	logic              start;
	cycle_kind_t       kind;
	logic [DATA_W-1:0] wdata;
	// Byte captured by a read cycle, valid once busy falls
	logic [DATA_W-1:0] rdata;
	logic              busy;

	modport ctrl (
		output start, kind, wdata,
		input  rdata, busy
	);

	modport unit (
		input  start, kind, wdata,
		output rdata, busy
	);
endinterface

// FSM to wait timer
// start loads count, done pulses once at the end
interface nand_timer_if;
	import nand_pkg::*;

	logic               start;
	logic [DELAY_W-1:0] count;
	// After the count, also hold until R/B# is high
	logic               wait_ready;
	logic               done;

	modport ctrl (
		output start, count, wait_ready,
		input  done
	);

	modport unit (
		input  start, count, wait_ready,
		output done
	);
endinterface

// File: src/nand_master.sv
//--------------------------------------------------------------------------
// NAND flash bus master, top level
// Command FSM, bus-cycle unit and wait timer on plain host and chip pins
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module nand_master #(
	parameter int T_WB  = 10,
	parameter int T_WHR = 6,
	parameter int T_WP  = 2
) (
	input  logic                        clk,
	input  logic                        nreset,
	// Host strobe interface
	input  logic                        activate,
	input  logic [7:0]                  cmd_in,
	input  logic [nand_pkg::DATA_W-1:0] data_in,
	output logic [nand_pkg::DATA_W-1:0] data_out,
	output logic                        busy,
	// NAND chip pins
	output logic                        nand_cle,
	output logic                        nand_ale,
	output logic                        nand_nwe,
	output logic                        nand_nre,
	output logic                        nand_nce,
	output logic                        nand_nwp,
	input  logic                        nand_rnb,
	inout  wire  [nand_pkg::DATA_W-1:0] nand_data
);
	import nand_pkg::*;

	nand_op_t          cmd_op;
	logic [DATA_W-1:0] dq_out;
	logic              dq_oe;

	nand_cycle_if cyc_if ();
	nand_timer_if tmr_if ();

	// Raw host byte to opcode type
	assign cmd_op = nand_op_t'(cmd_in);

	// Bus is released outside command, address and write cycles
	assign nand_data = dq_oe ? dq_out : 'z;

	nand_command_fsm #(
		.T_WB  (T_WB),
		.T_WHR (T_WHR)
	) command_fsm_i (
		.clk      (clk),
		.nreset   (nreset),
		.activate (activate),
		.cmd_in   (cmd_op),
		.data_in  (data_in),
		.data_out (data_out),
		.busy     (busy),
		.nce      (nand_nce),
		.nwp      (nand_nwp),
		.cyc      (cyc_if.ctrl),
		.tmr      (tmr_if.ctrl)
	);

	nand_cycle_unit #(
		.T_WP (T_WP)
	) cycle_unit_i (
		.clk    (clk),
		.nreset (nreset),
		.cyc    (cyc_if.unit),
		.cle    (nand_cle),
		.ale    (nand_ale),
		.nwe    (nand_nwe),
		.nre    (nand_nre),
		.dq_out (dq_out),
		.dq_oe  (dq_oe),
		.dq_in  (nand_data)
	);

	nand_wait_timer wait_timer_i (
		.clk    (clk),
		.nreset (nreset),
		.tmr    (tmr_if.unit),
		.rnb    (nand_rnb)
	);

endmodule

// File: src/nand_pkg.sv
//--------------------------------------------------------------------------
// NAND bus master shared definitions
// Opcodes, FSM states, bus-cycle kinds, chip command bytes and status bits
//--------------------------------------------------------------------------

package nand_pkg;

	// NAND data bus width, x8 only
	localparam int DATA_W = 8;

	// Width of the wait timer count
	localparam int DELAY_W = 16;

	// Host opcodes on cmd_in
	typedef enum logic [7:0] {
		OP_NAND_RESET     = 8'h01,
		OP_GET_STATUS     = 8'h02,
		OP_CHIP_ENABLE    = 8'h03,
		OP_CHIP_DISABLE   = 8'h04,
		OP_WRITE_PROTECT  = 8'h05,
		OP_WRITE_ENABLE   = 8'h06,
		OP_READ_STATUS    = 8'h07,
		OP_BYPASS_COMMAND = 8'h08,
		OP_BYPASS_ADDRESS = 8'h09,
		OP_BYPASS_DATA_WR = 8'h0A,
		OP_BYPASS_DATA_RD = 8'h0B
	} nand_op_t;

	// Command FSM states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_WAIT_CYCLE,
		ST_WAIT_TIMER,
		ST_FINISH
	} fsm_state_t;

	// Kind of one bus cycle on the NAND pins
	typedef enum logic [1:0] {
		CYC_CMD,
		CYC_ADDR,
		CYC_WRITE,
		CYC_READ
	} cycle_kind_t;

	// Chip command bytes
	localparam logic [7:0] NAND_CMD_RESET       = 8'hFF;
	localparam logic [7:0] NAND_CMD_READ_STATUS = 8'h70;

	// Status register layout, starts write protected
	localparam int         STATUS_CE_BIT = 2;
	localparam int         STATUS_WP_BIT = 3;
	localparam logic [7:0] STATUS_RESET  = 8'h08;

endpackage

// File: src/nand_wait_timer.sv
//--------------------------------------------------------------------------
// NAND wait timer
// Counts a programmed delay, then optionally waits for R/B# high
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module nand_wait_timer (
	input  logic       clk,
	input  logic       nreset,
	nand_timer_if.unit tmr,
	input  logic       rnb
);
	import nand_pkg::*;

	logic [DELAY_W-1:0] cnt;
	logic               running;
	logic               wait_q;
	logic               at_end;

	// Count of 0 behaves like 1
	assign at_end = (cnt <= DELAY_W'(1));

	// Done on the last count cycle or on the first later one with R/B# high
	assign tmr.done = running && at_end && (!wait_q || rnb);

	always_ff @(posedge clk) begin
		if (!nreset) begin
			running <= 1'b0;
		end else if (tmr.start) begin
			running <= 1'b1;
		end else if (tmr.done) begin
			running <= 1'b0;
		end
	end

	// Down-counter that parks at 1 during the ready wait
	always_ff @(posedge clk) begin
		if (tmr.start) begin
			cnt    <= tmr.count;
			wait_q <= tmr.wait_ready;
		end else if (running && !at_end) begin
			cnt <= cnt - DELAY_W'(1);
		end
	end

	// A new delay only after done
	a_no_restart: assert property (@(posedge clk) disable iff (!nreset)
		tmr.start |-> !running);

endmodule

// File: testbench/nand_chip_model.sv
//--------------------------------------------------------------------------
// Behavioral x8 NAND chip for the bus master testbench
// Latches command, address and data bytes, answers reads, drives R/B#
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module nand_chip_model (
	input  logic       clk,
	input  logic       nreset,
	input  logic       cle,
	input  logic       ale,
	input  logic       nwe,
	input  logic       nre,
	inout  wire  [7:0] data,
	output logic       rnb,
	output logic [7:0] last_cmd,
	output logic [7:0] last_addr,
	output logic [7:0] last_data
);
	logic       nwe_q;
	logic [4:0] busy_cnt;
	logic [7:0] rd_byte;

	// Chip is ready once the reset busy time has run out
	assign rnb = (busy_cnt == 5'd0);

	// Status byte after READ STATUS, else scrambled echo of the last write
	assign rd_byte = (last_cmd == 8'h70) ? 8'hE0 : (last_data ^ 8'h5A);

	// Drive the bus only while RE# is low
	assign data = nre ? 8'hzz : rd_byte;

	always_ff @(posedge clk) begin
		if (!nreset) begin
			nwe_q     <= 1'b1;
			busy_cnt  <= 5'd0;
			last_cmd  <= 8'h00;
			last_addr <= 8'h00;
			last_data <= 8'h00;
		end else begin
			nwe_q <= nwe;
			if (busy_cnt != 5'd0) begin
				busy_cnt <= busy_cnt - 5'd1;
			end
			// Rising WE# latches the byte, CLE and ALE pick the register
			if (nwe && !nwe_q) begin
				if (cle) begin
					last_cmd <= data;
					// RESET keeps the chip busy for a while
					if (data == 8'hFF) begin
						busy_cnt <= 5'd20;
					end
				end else if (ale) begin
					last_addr <= data;
				end else begin
					last_data <= data;
				end
			end
		end
	end

endmodule

// File: testbench/tb_nand_master.sv
//--------------------------------------------------------------------------
// Testbench for the NAND flash bus master
// Drives host opcodes against a behavioral chip and checks every result
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_nand_master;
	import nand_pkg::*;

	// Longest wait for busy to fall, in clock cycles
	localparam int TIMEOUT = 200;

	logic       clk;
	logic       nreset;
	logic       activate;
	logic [7:0] cmd_in;
	logic [7:0] data_in;
	logic [7:0] data_out;
	logic       busy;
	logic       nand_cle;
	logic       nand_ale;
	logic       nand_nwe;
	logic       nand_nre;
	logic       nand_nce;
	logic       nand_nwp;
	logic       nand_rnb;
	wire  [7:0] nand_data;

	// Chip latches, seen from the model
	logic [7:0] last_cmd;
	logic [7:0] last_addr;
	logic [7:0] last_data;

	logic [31:0] lcg_state;
	int          errors;
	int          tests;
	int          failed_tests;
	int          start_errors;
	string       test_name;

	nand_master #(
		.T_WB  (10),
		.T_WHR (6),
		.T_WP  (2)
	) nand_master_i (
		.clk       (clk),
		.nreset    (nreset),
		.activate  (activate),
		.cmd_in    (cmd_in),
		.data_in   (data_in),
		.data_out  (data_out),
		.busy      (busy),
		.nand_cle  (nand_cle),
		.nand_ale  (nand_ale),
		.nand_nwe  (nand_nwe),
		.nand_nre  (nand_nre),
		.nand_nce  (nand_nce),
		.nand_nwp  (nand_nwp),
		.nand_rnb  (nand_rnb),
		.nand_data (nand_data)
	);

	nand_chip_model chip_model_i (
		.clk       (clk),
		.nreset    (nreset),
		.cle       (nand_cle),
		.ale       (nand_ale),
		.nwe       (nand_nwe),
		.nre       (nand_nre),
		.data      (nand_data),
		.rnb       (nand_rnb),
		.last_cmd  (last_cmd),
		.last_addr (last_addr),
		.last_data (last_data)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//----------------------------------------------------------------------
	// Bus protocol checks
	//----------------------------------------------------------------------
	// One latch enable at a time
	cle_ale_exclusive: assert property (@(posedge clk) disable iff (!nreset)
		!(nand_cle && nand_ale))
		else begin
			$display("FAIL %s: CLE and ALE were high together", test_name);
			errors++;
		end

	// Sequences end only with the chip ready
	busy_waits_ready: assert property (@(posedge clk) disable iff (!nreset)
		$fell(busy) |-> nand_rnb)
		else begin
			$display("FAIL %s: busy fell while R/B# was low", test_name);
			errors++;
		end

	//----------------------------------------------------------------------
	// Helpers
	//----------------------------------------------------------------------
	// LCG, upper bits give the byte
	function automatic logic [7:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];
	endfunction

	task automatic compare_byte(input string what, input logic [7:0] exp,
		input logic [7:0] act);
		assert (act === exp)
			else begin
				$display("FAIL %s %s: expected 8'h%02h, actual 8'h%02h",
					test_name, what, exp, act);
				errors++;
			end
	endtask

	task automatic confirm(input logic cond, input string msg);
		assert (cond)
			else begin
				$display("FAIL %s: %s", test_name, msg);
				errors++;
			end
	endtask

	task automatic begin_test(input string name);
		test_name    = name;
		start_errors = errors;
		tests++;
	endtask

	task automatic end_test();
		if (errors > start_errors) begin
			failed_tests++;
			$display("test %s: %0d failed checks", test_name, errors - start_errors);
		end else begin
			$display("test %s: ok", test_name);
		end
	endtask

	// One-cycle activate, returns just after the DUT has sampled it
	task automatic send_op(input logic [7:0] op, input logic [7:0] data);
		@(posedge clk);
		#1;
		activate = 1'b1;
		cmd_in   = op;
		data_in  = data;
		@(posedge clk);
		#1;
		activate = 1'b0;
	endtask

	task automatic wait_idle(output int cycles);
		cycles = 0;
		while (busy && cycles < TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		confirm(!busy, "busy did not fall before the timeout");
	endtask

	// Controller-only opcode, busy for exactly one cycle
	task automatic run_local_op(input logic [7:0] op);
		send_op(op, 8'h00);
		confirm(busy, "busy did not rise on a valid opcode");
		@(posedge clk);
		#1;
		confirm(!busy, "busy lasted more than one cycle");
	endtask

	task automatic verify_status(input logic [7:0] exp);
		int cycles;
		send_op(OP_GET_STATUS, 8'h00);
		wait_idle(cycles);
		compare_byte("status", exp, data_out);
	endtask

	//----------------------------------------------------------------------
	// Test sequence
	//----------------------------------------------------------------------
	initial begin
		int         cycles;
		logic [7:0] b;
		logic [7:0] exp_status;

		errors       = 0;
		tests        = 0;
		failed_tests = 0;
		start_errors = 0;
		lcg_state    = 32'h76644d94;
		test_name    = "reset";
		nreset       = 1'b0;
		activate     = 1'b0;
		cmd_in       = 8'h00;
		data_in      = 8'h00;
		repeat (2) @(posedge clk);
		#1;
		nreset = 1'b1;

		// Bits: bus drive, busy, CLE, ALE, WE#, RE#, CE#, WP#
		begin_test("reset_values");
		compare_byte("pins", 8'b0000_1110, {nand_master_i.dq_oe, busy, nand_cle,
			nand_ale, nand_nwe, nand_nre, nand_nce, nand_nwp});
		verify_status(8'h08);
		end_test();

		begin_test("chip_pins");
		exp_status = STATUS_RESET;
		run_local_op(OP_CHIP_ENABLE);
		exp_status[STATUS_CE_BIT] = 1'b1;
		compare_byte("CE#", 8'h00, {7'd0, nand_nce});
		verify_status(exp_status);
		run_local_op(OP_WRITE_ENABLE);
		exp_status[STATUS_WP_BIT] = 1'b0;
		compare_byte("WP#", 8'h01, {7'd0, nand_nwp});
		verify_status(exp_status);
		run_local_op(OP_WRITE_PROTECT);
		exp_status[STATUS_WP_BIT] = 1'b1;
		compare_byte("WP#", 8'h00, {7'd0, nand_nwp});
		verify_status(exp_status);
		run_local_op(OP_CHIP_DISABLE);
		exp_status[STATUS_CE_BIT] = 1'b0;
		compare_byte("CE#", 8'h01, {7'd0, nand_nce});
		verify_status(exp_status);
		end_test();

		begin_test("bypass_writes");
		for (int i = 0; i < 4; i++) begin
			b = next_random();
			// Keep clear of RESET and READ STATUS
			if (b == 8'hFF || b == 8'h70) begin
				b = b ^ 8'h01;
			end
			send_op(OP_BYPASS_COMMAND, b);
			wait_idle(cycles);
			compare_byte("last command", b, last_cmd);
			b = next_random();
			send_op(OP_BYPASS_ADDRESS, b);
			wait_idle(cycles);
			compare_byte("last address", b, last_addr);
			b = next_random();
			send_op(OP_BYPASS_DATA_WR, b);
			wait_idle(cycles);
			compare_byte("last data", b, last_data);
		end
		end_test();

		begin_test("bypass_read");
		for (int i = 0; i < 3; i++) begin
			b = next_random();
			send_op(OP_BYPASS_DATA_WR, b);
			wait_idle(cycles);
			send_op(OP_BYPASS_DATA_RD, 8'h00);
			wait_idle(cycles);
			compare_byte("read byte", b ^ 8'h5A, data_out);
		end
		end_test();

		// Chip stays busy 20 cycles after FF
		begin_test("nand_reset");
		send_op(OP_NAND_RESET, 8'h00);
		wait_idle(cycles);
		compare_byte("last command", 8'hFF, last_cmd);
		confirm(cycles > 20, "NAND reset ended before the chip went ready");
		send_op(OP_READ_STATUS, 8'h00);
		wait_idle(cycles);
		compare_byte("status byte", 8'hE0, data_out);
		compare_byte("last command", 8'h70, last_cmd);
		end_test();

		begin_test("invalid_opcode");
		send_op(8'h00, 8'h00);
		for (int i = 0; i < 4; i++) begin
			confirm(!busy, "busy rose on opcode 8'h00");
			@(posedge clk);
			#1;
		end
		send_op(8'h0C, 8'h00);
		for (int i = 0; i < 4; i++) begin
			confirm(!busy, "busy rose on opcode 8'h0C");
			@(posedge clk);
			#1;
		end
		verify_status(exp_status);
		end_test();

		$display("Tests run: %0d, tests failed: %0d, failed checks: %0d",
			tests, failed_tests, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
